// ==== design/tlb_pkg.sv ====
package tlb_pkg;

    localparam int TLB_NUM   = 16;
    localparam int TLB_IDX_W = 4;
    localparam int ASID_W    = 10;
    localparam int VPPN_W    = 19;
    localparam int PPN_W     = 20;

    // Any other page size code means 4 MB
    localparam logic [5:0] PS_4K = 6'd12;

    typedef logic [ASID_W-1:0]    asid_t;
    typedef logic [VPPN_W-1:0]    vppn_t;
    typedef logic [PPN_W-1:0]     ppn_t;
    typedef logic [TLB_IDX_W-1:0] tlb_idx_t;
    typedef logic [31:0]          vaddr_t;
    typedef logic [31:0]          paddr_t;

    typedef struct packed {
        logic       v;
        logic       d;
        logic [1:0] mat;
        logic [1:0] plv;
        ppn_t       ppn;
    } tlb_page_t;

    typedef struct packed {
        logic       e;
        asid_t      asid;
        logic       g;
        logic [5:0] ps;
        vppn_t      vppn;
    } tlb_cmp_t;

    typedef struct packed {
        tlb_cmp_t  cmp;
        tlb_page_t even;
        tlb_page_t odd;
    } tlb_entry_t;

    typedef enum logic [2:0] {
        INV_ALL0       = 3'd0,
        INV_ALL1       = 3'd1,
        INV_GLOBAL     = 3'd2,
        INV_NONGLOBAL  = 3'd3,
        INV_ASID       = 3'd4,
        INV_ASID_VA    = 3'd5,
        INV_GORASID_VA = 3'd6
    } inv_op_e;

    // Selection flags broadcast to every entry
    typedef struct packed {
        logic  valid;
        logic  sel_g;
        logic  sel_nong;
        logic  need_asid;
        logic  need_vppn;
        logic  allow_g_or_asid;
        asid_t asid;
        vppn_t vppn;
    } inv_cmd_t;

    typedef struct packed {
        logic       hit;
        paddr_t     pa;
        logic       v;
        logic       d;
        logic [1:0] mat;
    } lookup_res_t;

endpackage

// ==== design/tlb_update.sv ====
`timescale 1ns/1ps

module tlb_update (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        wr_valid,
    input  tlb_pkg::tlb_idx_t           wr_idx,
    input  logic                        inv_valid,
    input  tlb_pkg::inv_op_e            inv_op,
    input  tlb_pkg::asid_t              inv_asid,
    input  tlb_pkg::vppn_t              inv_vppn,
    output logic [tlb_pkg::TLB_NUM-1:0] wr_en,
    output tlb_pkg::inv_cmd_t           inv_cmd
);
    import tlb_pkg::*;

    always_comb begin
        wr_en = '0;
        if (wr_valid) begin
            wr_en[wr_idx] = 1'b1;
        end
    end

    // Write wins over a same-cycle invalidate
    always_comb begin
        inv_cmd       = '0;
        inv_cmd.valid = inv_valid & ~wr_valid;
        inv_cmd.asid  = inv_asid;
        inv_cmd.vppn  = inv_vppn;
        case (inv_op)
            INV_ALL0, INV_ALL1: begin
                inv_cmd.sel_g    = 1'b1;
                inv_cmd.sel_nong = 1'b1;
            end
            INV_GLOBAL:    inv_cmd.sel_g = 1'b1;
            INV_NONGLOBAL: inv_cmd.sel_nong = 1'b1;
            INV_ASID: begin
                inv_cmd.sel_nong  = 1'b1;
                inv_cmd.need_asid = 1'b1;
            end
            INV_ASID_VA: begin
                inv_cmd.sel_nong  = 1'b1;
                inv_cmd.need_asid = 1'b1;
                inv_cmd.need_vppn = 1'b1;
            end
            INV_GORASID_VA: begin
                inv_cmd.allow_g_or_asid = 1'b1;
                inv_cmd.need_vppn       = 1'b1;
            end
            // Reserved code selects nothing
            default: inv_cmd.valid = 1'b0;
        endcase
    end

endmodule

// ==== design/tlb_entry.sv ====
`timescale 1ns/1ps

module tlb_entry (
    input  logic                clk,
    input  logic                rstn,
    input  logic                stall,
    input  logic                lu_req,
    input  tlb_pkg::vaddr_t     lu_va,
    input  tlb_pkg::asid_t      csr_asid,
    input  tlb_pkg::vppn_t      srch_vppn,
    input  logic                wr_en,
    input  tlb_pkg::tlb_entry_t wr_entry,
    input  tlb_pkg::inv_cmd_t   inv_cmd,
    output logic                lu_hit_q,
    output tlb_pkg::paddr_t     lu_pa_q,
    output tlb_pkg::tlb_page_t  lu_page_q,
    output logic                srch_match
);
    import tlb_pkg::*;

    tlb_entry_t ent;
    tlb_entry_t cur;
    logic       e_q;
    logic       is_4k;
    vppn_t      vppn_mask;
    logic       asid_ok;
    logic       lu_hit;
    logic       lu_odd;
    tlb_page_t  lu_page;
    paddr_t     lu_pa;
    logic       inv_asid_eq;
    logic       inv_sel;
    logic       inv_hit;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ent <= wr_entry;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            e_q <= 1'b0;
        end else if (wr_en) begin
            e_q <= wr_entry.cmp.e;
        end else if (inv_hit) begin
            e_q <= 1'b0;
        end
    end

    always_comb begin
        cur       = ent;
        cur.cmp.e = e_q;
    end

    // 4 MB pages only compare the upper 10 vppn bits
    assign is_4k     = (cur.cmp.ps == PS_4K);
    assign vppn_mask = is_4k ? '1 : {{(VPPN_W-9){1'b1}}, 9'b0};
    assign asid_ok   = cur.cmp.g | (cur.cmp.asid == csr_asid);

    assign lu_hit  = lu_req & cur.cmp.e & asid_ok
                   & (((cur.cmp.vppn ^ lu_va[31:13]) & vppn_mask) == '0);
    assign lu_odd  = is_4k ? lu_va[12] : lu_va[21];
    assign lu_page = lu_odd ? cur.odd : cur.even;
    assign lu_pa   = is_4k ? {lu_page.ppn, lu_va[11:0]}
                           : {lu_page.ppn[PPN_W-1:9], lu_va[20:0]};

    assign srch_match = cur.cmp.e & asid_ok
                      & (((cur.cmp.vppn ^ srch_vppn) & vppn_mask) == '0);

    assign inv_asid_eq = (cur.cmp.asid == inv_cmd.asid);
    assign inv_sel     = inv_cmd.allow_g_or_asid ? (cur.cmp.g | inv_asid_eq)
                       : ((cur.cmp.g ? inv_cmd.sel_g : inv_cmd.sel_nong)
                          & (~inv_cmd.need_asid | inv_asid_eq));
    assign inv_hit     = inv_cmd.valid & cur.cmp.e & inv_sel
                       & (~inv_cmd.need_vppn
                          | (((cur.cmp.vppn ^ inv_cmd.vppn) & vppn_mask) == '0));

    // Stage 1, zeroed on a miss so the merge can OR
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lu_hit_q  <= 1'b0;
            lu_pa_q   <= '0;
            lu_page_q <= '0;
        end else if (!stall) begin
            lu_hit_q  <= lu_hit;
            lu_pa_q   <= lu_hit ? lu_pa : '0;
            lu_page_q <= lu_hit ? lu_page : '0;
        end
    end

endmodule

// ==== design/tlb_hit_merge.sv ====
`timescale 1ns/1ps

module tlb_hit_merge (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        stall,
    input  logic                        lu_req,
    input  logic [tlb_pkg::TLB_NUM-1:0] lu_hit_vec,
    input  tlb_pkg::paddr_t             lu_pa_vec [tlb_pkg::TLB_NUM],
    input  tlb_pkg::tlb_page_t          lu_page_vec [tlb_pkg::TLB_NUM],
    input  logic                        srch_valid,
    input  logic [tlb_pkg::TLB_NUM-1:0] srch_match_vec,
    output logic                        lu_valid,
    output tlb_pkg::lookup_res_t        lu_res,
    output logic                        srch_done,
    output logic                        srch_hit,
    output tlb_pkg::tlb_idx_t           srch_idx
);
    import tlb_pkg::*;

    logic       lu_req_q;
    paddr_t     pa_or;
    logic [3:0] attr_or;
    tlb_idx_t   srch_sel;

    // At most one entry hits, misses are all zero
    always_comb begin
        pa_or   = '0;
        attr_or = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            pa_or   = pa_or | lu_pa_vec[i];
            attr_or = attr_or | {lu_page_vec[i].v, lu_page_vec[i].d, lu_page_vec[i].mat};
        end
    end

    // Lowest index wins
    always_comb begin
        srch_sel = '0;
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (srch_match_vec[i]) begin
                srch_sel = tlb_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lu_req_q <= 1'b0;
            lu_valid <= 1'b0;
            lu_res   <= '0;
        end else if (!stall) begin
            lu_req_q   <= lu_req;
            lu_valid   <= lu_req_q;
            lu_res.hit <= |lu_hit_vec;
            lu_res.pa  <= pa_or;
            lu_res.v   <= attr_or[3];
            lu_res.d   <= attr_or[2];
            lu_res.mat <= attr_or[1:0];
        end
    end

    // Search runs regardless of stall
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            srch_done <= 1'b0;
            srch_hit  <= 1'b0;
            srch_idx  <= '0;
        end else begin
            srch_done <= srch_valid;
            if (srch_valid) begin
                srch_hit <= |srch_match_vec;
                srch_idx <= srch_sel;
            end
        end
    end

endmodule

// ==== design/tlb_top.sv ====
`timescale 1ns/1ps

module tlb_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 stall,
    input  logic                 lu_req,
    input  tlb_pkg::vaddr_t      lu_va,
    output logic                 lu_valid,
    output tlb_pkg::lookup_res_t lu_res,
    input  tlb_pkg::asid_t       csr_asid,
    input  logic                 wr_valid,
    input  tlb_pkg::tlb_idx_t    wr_idx,
    input  tlb_pkg::tlb_entry_t  wr_entry,
    input  logic                 inv_valid,
    input  tlb_pkg::inv_op_e     inv_op,
    input  tlb_pkg::asid_t       inv_asid,
    input  tlb_pkg::vppn_t       inv_vppn,
    input  logic                 srch_valid,
    input  tlb_pkg::vppn_t       srch_vppn,
    output logic                 srch_done,
    output logic                 srch_hit,
    output tlb_pkg::tlb_idx_t    srch_idx
);
    import tlb_pkg::*;

    logic [TLB_NUM-1:0] wr_en;
    inv_cmd_t           inv_cmd;
    logic [TLB_NUM-1:0] lu_hit_vec;
    paddr_t             lu_pa_vec [TLB_NUM];
    tlb_page_t          lu_page_vec [TLB_NUM];
    logic [TLB_NUM-1:0] srch_match_vec;

    tlb_update u_update (
        .clk      (clk),
        .rstn     (rstn),
        .wr_valid (wr_valid),
        .wr_idx   (wr_idx),
        .inv_valid(inv_valid),
        .inv_op   (inv_op),
        .inv_asid (inv_asid),
        .inv_vppn (inv_vppn),
        .wr_en    (wr_en),
        .inv_cmd  (inv_cmd)
    );

    for (genvar i = 0; i < TLB_NUM; i++) begin : g_entry
        tlb_entry u_entry (
            .clk       (clk),
            .rstn      (rstn),
            .stall     (stall),
            .lu_req    (lu_req),
            .lu_va     (lu_va),
            .csr_asid  (csr_asid),
            .srch_vppn (srch_vppn),
            .wr_en     (wr_en[i]),
            .wr_entry  (wr_entry),
            .inv_cmd   (inv_cmd),
            .lu_hit_q  (lu_hit_vec[i]),
            .lu_pa_q   (lu_pa_vec[i]),
            .lu_page_q (lu_page_vec[i]),
            .srch_match(srch_match_vec[i])
        );
    end

    tlb_hit_merge u_merge (
        .clk           (clk),
        .rstn          (rstn),
        .stall         (stall),
        .lu_req        (lu_req),
        .lu_hit_vec    (lu_hit_vec),
        .lu_pa_vec     (lu_pa_vec),
        .lu_page_vec   (lu_page_vec),
        .srch_valid    (srch_valid),
        .srch_match_vec(srch_match_vec),
        .lu_valid      (lu_valid),
        .lu_res        (lu_res),
        .srch_done     (srch_done),
        .srch_hit      (srch_hit),
        .srch_idx      (srch_idx)
    );

endmodule

// ==== verification/tlb_checker.sv ====
`timescale 1ns/1ps

module tlb_checker (
    input logic                 clk,
    input logic                 rstn,
    input logic                 stall,
    input logic                 lu_req,
    input logic                 lu_valid,
    input tlb_pkg::lookup_res_t lu_res,
    input logic                 srch_done
);
    import tlb_pkg::*;

    // Search done is a single-cycle pulse
    a_srch_pulse: assert property (@(posedge clk) disable iff (!rstn)
        srch_done |=> !srch_done) else $error("srch_done held longer than one cycle");

    a_lu_latency: assert property (@(posedge clk) disable iff (!rstn)
        (lu_req && !stall) ##1 !stall |=> lu_valid)
        else $error("lu_valid missing two cycles after lu_req");

    a_stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        stall |=> ($stable(lu_valid) && $stable(lu_res)))
        else $error("lookup outputs changed under stall");

    a_hit_valid: assert property (@(posedge clk) disable iff (!rstn)
        lu_res.hit |-> lu_valid) else $error("lu_res.hit without lu_valid");

endmodule

bind tlb_top tlb_checker u_checker (
    .clk(clk), .rstn(rstn), .stall(stall), .lu_req(lu_req),
    .lu_valid(lu_valid), .lu_res(lu_res), .srch_done(srch_done)
);

// ==== verification/tlb_tb.sv ====
`timescale 1ns/1ps

module tlb_tb;
    import tlb_pkg::*;

    // Test 4 with its seven table fills dominates the run length
    localparam int FILL_CYC     = 2 * TLB_NUM + 4;
    localparam int INV_TEST_CYC = 7 * (FILL_CYC + 4 + TLB_NUM * 8);
    localparam int TIMEOUT_CYC  = 20 + FILL_CYC * 2 + 200 + INV_TEST_CYC + 300 + 1000;

    logic clk = 1'b0;
    logic rstn, stall, lu_req, lu_valid, wr_valid, inv_valid, srch_valid;
    logic srch_done, srch_hit;
    vaddr_t lu_va;
    lookup_res_t lu_res, res_prev, exp_res;
    asid_t csr_asid, inv_asid;
    tlb_idx_t wr_idx, srch_idx, exp_idx;
    tlb_entry_t wr_entry, ent;
    inv_op_e inv_op;
    vppn_t inv_vppn, srch_vppn;

    tlb_entry_t  tbl [TLB_NUM];
    lookup_res_t exp_q [$];
    logic [31:0] seed = 32'hd926;
    logic [31:0] pick;
    logic stall_prev = 1'b0, valid_prev = 1'b0, srch_pend = 1'b0, exp_hit;
    int errors = 0, checks = 0, tests = 0, cycles = 0, err_mark;

    always #10 clk = ~clk;

    tlb_top u_dut (.*);

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic vppn_match(tlb_entry_t e, vppn_t vppn);
        if (e.cmp.ps == PS_4K) return e.cmp.vppn == vppn;
        return e.cmp.vppn[18:9] == vppn[18:9];
    endfunction

    function automatic lookup_res_t model_lookup(vaddr_t va, asid_t asid);
        lookup_res_t r;
        tlb_page_t   pg;
        logic        is4k;
        r = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (tbl[i].cmp.e && (tbl[i].cmp.g || tbl[i].cmp.asid == asid)
                && vppn_match(tbl[i], va[31:13])) begin
                is4k  = (tbl[i].cmp.ps == PS_4K);
                pg    = (is4k ? va[12] : va[21]) ? tbl[i].odd : tbl[i].even;
                r.hit = 1'b1;
                r.pa  = is4k ? {pg.ppn, va[11:0]} : {pg.ppn[19:9], va[20:0]};
                r.v   = pg.v;
                r.d   = pg.d;
                r.mat = pg.mat;
            end
        end
        return r;
    endfunction

    // Upper vppn bits carry the index so distinct slots never overlap
    function automatic tlb_entry_t rand_entry(int idx);
        tlb_entry_t  e;
        logic [31:0] r;
        logic [31:0] low;
        r   = next_rand();
        low = next_rand();
        e.cmp.e    = 1'b1;
        e.cmp.asid = asid_t'(r[1:0]);
        e.cmp.g    = r[5];
        e.cmp.ps   = r[9] ? PS_4K : 6'd21;
        e.cmp.vppn = {idx[3:0], low[14:0]};
        e.even     = tlb_page_t'(next_rand());
        e.odd      = tlb_page_t'(next_rand());
        return e;
    endfunction

    function automatic vaddr_t va_inside(tlb_entry_t e);
        logic [31:0] r;
        r = next_rand();
        if (e.cmp.ps == PS_4K) return {e.cmp.vppn, r[12:0]};
        return {e.cmp.vppn[18:9], r[21:0]};
    endfunction

    task automatic write_entry(int idx, tlb_entry_t e);
        @(posedge clk);
        wr_valid <= 1'b1;
        wr_idx   <= tlb_idx_t'(idx);
        wr_entry <= e;
        @(posedge clk);
        wr_valid <= 1'b0;
        tbl[idx] = e;
    endtask

    task automatic fill_table();
        for (int i = 0; i < TLB_NUM; i++) write_entry(i, rand_entry(i));
    endtask

    task automatic issue_lookup(vaddr_t va, asid_t asid, logic stall_v);
        @(posedge clk);
        lu_req   <= 1'b1;
        lu_va    <= va;
        csr_asid <= asid;
        stall    <= stall_v;
    endtask

    task automatic drain_lookups();
        @(posedge clk);
        lu_req <= 1'b0;
        stall  <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    task automatic run_search(vppn_t vppn, asid_t asid);
        @(posedge clk);
        srch_valid <= 1'b1;
        srch_vppn  <= vppn;
        csr_asid   <= asid;
        @(posedge clk);
        srch_valid <= 1'b0;
        while (srch_pend) @(posedge clk);
    endtask

    task automatic invalidate(inv_op_e op, asid_t asid, vppn_t vppn);
        logic sel;
        @(posedge clk);
        inv_valid <= 1'b1;
        inv_op    <= op;
        inv_asid  <= asid;
        inv_vppn  <= vppn;
        @(posedge clk);
        inv_valid <= 1'b0;
        for (int i = 0; i < TLB_NUM; i++) begin
            case (op)
                INV_GLOBAL:    sel = tbl[i].cmp.g;
                INV_NONGLOBAL: sel = !tbl[i].cmp.g;
                INV_ASID:      sel = !tbl[i].cmp.g && tbl[i].cmp.asid == asid;
                INV_ASID_VA:   sel = !tbl[i].cmp.g && tbl[i].cmp.asid == asid
                                     && vppn_match(tbl[i], vppn);
                INV_GORASID_VA: sel = (tbl[i].cmp.g || tbl[i].cmp.asid == asid)
                                      && vppn_match(tbl[i], vppn);
                default:       sel = 1'b1;
            endcase
            if (sel) tbl[i].cmp.e = 1'b0;
        end
    endtask

    task automatic end_test(string name);
        tests++;
        $display("test %0d %s: %s (%0d errors)", tests, name,
                 (errors == err_mark) ? "ok" : "FAILED", errors - err_mark);
        err_mark = errors;
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rstn) begin
            if (lu_req && !stall) exp_q.push_back(model_lookup(lu_va, csr_asid));
            if (lu_valid && !stall_prev) begin
                checks++;
                assert (exp_q.size() != 0) else begin
                    $display("lu_valid at %0t with no lookup in flight", $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_res = exp_q.pop_front();
                    assert (lu_res == exp_res) else begin
                        $display("mismatch at %0t: lu_res expected %h got %h",
                                 $time, exp_res, lu_res);
                        errors++;
                    end
                end
            end else if (stall_prev) begin
                checks++;
                assert (lu_res == res_prev) else begin
                    $display("mismatch at %0t: lu_res expected %h got %h",
                             $time, res_prev, lu_res);
                    errors++;
                end
                assert (lu_valid == valid_prev) else begin
                    $display("mismatch at %0t: lu_valid expected %0b got %0b",
                             $time, valid_prev, lu_valid);
                    errors++;
                end
            end
            res_prev   = lu_res;
            valid_prev = lu_valid;
            stall_prev = stall;
            if (srch_done) begin
                checks++;
                assert (srch_pend) else begin
                    $display("srch_done at %0t without a search", $time);
                    errors++;
                end
                assert (srch_hit == exp_hit) else begin
                    $display("mismatch at %0t: srch_hit expected %0b got %0b",
                             $time, exp_hit, srch_hit);
                    errors++;
                end
                assert (!exp_hit || srch_idx == exp_idx) else begin
                    $display("mismatch at %0t: srch_idx expected %0d got %0d",
                             $time, exp_idx, srch_idx);
                    errors++;
                end
                srch_pend = 1'b0;
            end
            if (srch_valid) begin
                srch_pend = 1'b1;
                exp_hit   = 1'b0;
                exp_idx   = '0;
                // First matching slot from index 0 upward
                for (int i = 0; i < TLB_NUM; i++) begin
                    if (!exp_hit && tbl[i].cmp.e
                        && (tbl[i].cmp.g || tbl[i].cmp.asid == csr_asid)
                        && vppn_match(tbl[i], srch_vppn)) begin
                        exp_hit = 1'b1;
                        exp_idx = tlb_idx_t'(i);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYC) begin
            $display("timeout: run exceeded %0d cycles", TIMEOUT_CYC);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        rstn       = 1'b0;
        stall      = 1'b0;
        lu_req     = 1'b0;
        lu_va      = '0;
        csr_asid   = '0;
        wr_valid   = 1'b0;
        wr_idx     = '0;
        wr_entry   = '0;
        inv_valid  = 1'b0;
        inv_op     = INV_ALL0;
        inv_asid   = '0;
        inv_vppn   = '0;
        srch_valid = 1'b0;
        srch_vppn  = '0;
        for (int i = 0; i < TLB_NUM; i++) tbl[i] = '0;
        err_mark = 0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;

        fill_table();
        for (int i = 0; i < TLB_NUM; i++) issue_lookup(va_inside(tbl[i]), tbl[i].cmp.asid, 1'b0);
        drain_lookups();
        end_test("lookup hits");

        ent = rand_entry(3);
        ent.cmp.e = 1'b0;
        write_entry(3, ent);
        ent = rand_entry(5);
        ent.cmp.g = 1'b0;
        ent.cmp.asid = 10'd2;
        write_entry(5, ent);
        ent = rand_entry(7);
        ent.cmp.g = 1'b1;
        write_entry(7, ent);
        issue_lookup(va_inside(tbl[3]), tbl[3].cmp.asid, 1'b0);
        issue_lookup(va_inside(tbl[5]), 10'd3, 1'b0);
        issue_lookup(va_inside(tbl[7]), asid_t'(next_rand()), 1'b0);
        issue_lookup(va_inside(tbl[9]) ^ 32'h0080_0000, tbl[9].cmp.asid, 1'b0);
        drain_lookups();
        end_test("misses and global");

        ent = rand_entry(2);
        ent.cmp.g = 1'b1;
        write_entry(2, ent);
        write_entry(6, ent);
        write_entry(11, ent);
        run_search(ent.cmp.vppn, 10'd0);
        run_search({4'd6, 15'd0}, 10'd0);
        end_test("search priority");

        for (int op = 0; op < 7; op++) begin
            fill_table();
            invalidate(inv_op_e'(op), asid_t'(next_rand() % 4),
                       tbl[next_rand() % TLB_NUM].cmp.vppn);
            for (int i = 0; i < TLB_NUM; i++) begin
                issue_lookup(va_inside(tbl[i]), tbl[i].cmp.asid, 1'b0);
            end
            drain_lookups();
            for (int i = 0; i < TLB_NUM; i++) run_search(tbl[i].cmp.vppn, tbl[i].cmp.asid);
        end
        end_test("invalidate ops");

        fill_table();
        for (int n = 0; n < 60; n++) begin
            pick = next_rand();
            issue_lookup(pick[4] ? va_inside(tbl[next_rand() % TLB_NUM]) : next_rand(),
                         asid_t'(next_rand() % 4), (next_rand() % 3) == 0);
        end
        drain_lookups();
        end_test("stall stream");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
design/tlb_pkg.sv
design/tlb_update.sv
design/tlb_entry.sv
design/tlb_hit_merge.sv
design/tlb_top.sv
verification/tlb_checker.sv
verification/tlb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the log
verilator --binary --timing --assert --top-module tlb_tb -f build.f -Mdir obj_dir \
    > build.log 2>&1 || { echo "compile failed, see build.log"; exit 1; }
./obj_dir/Vtlb_tb > sim.log 2>&1 || echo "simulator returned an error status"
grep -q "Simulation finished: PASS" sim.log && echo "run ok" || { echo "run failed"; exit 1; }
